/* hdl/procPkg.sv */
/*
 * Shared types, opcodes and instruction field positions for the
 * five-stage 16-bit pipelined processor
 */
package procPkg;

   localparam int WORD_W     = 16;
   localparam int REG_COUNT  = 8;
   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [2:0]        regAddr_t;
   typedef logic [7:0]        dAddr_t;
   typedef logic [7:0]        iAddr_t;

   // Instruction fields
   localparam int OPC_MSB  = 15;
   localparam int OPC_LSB  = 11;
   localparam int RS_MSB   = 10;
   localparam int RS_LSB   = 8;
   localparam int RT_MSB   = 7;
   localparam int RT_LSB   = 5;
   localparam int RD_MSB   = 4;
   localparam int RD_LSB   = 2;
   localparam int IMM5_MSB = 4;
   localparam int BOFF_MSB = 7;
   localparam int JOFF_MSB = 10;

   // All-zero word decodes as NOP, so bubbles and reset values line up
   localparam word_t NOP_INSTR = 16'h0000;

   typedef enum logic [4:0] {
      OP_NOP  = 5'h00,
      OP_HALT = 5'h01,
      OP_ADD  = 5'h02,
      OP_SUB  = 5'h03,
      OP_AND  = 5'h04,
      OP_XOR  = 5'h05,
      OP_ADDI = 5'h06,
      OP_LD   = 5'h07,
      OP_ST   = 5'h08,
      OP_BEQZ = 5'h09,
      OP_BNEZ = 5'h0a,
      OP_J    = 5'h0b
   } opcode_t;

   typedef enum logic [2:0] {
      ALU_PASS_B,
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR
   } aluOp_t;

   typedef enum logic [1:0] {
      BR_NONE,
      BR_EQZ,
      BR_NEZ,
      BR_JMP
   } brKind_t;

endpackage

/* hdl/fetch.sv */
`timescale 1ns/1ps
/*
 * Fetch stage: program counter, loadable instruction memory and the
 * fetch-to-decode register
 */
module fetch (
   input  logic            clk,
   input  logic            rstN,
   input  logic            progWe,
   input  procPkg::iAddr_t progAddr,
   input  procPkg::word_t  progData,
   input  logic            run,
   input  logic            stall,
   input  logic            halt,
   input  logic            redirect,
   input  procPkg::word_t  target,
   output procPkg::word_t  instr,
   output procPkg::word_t  pcNext
);

   procPkg::word_t imem [procPkg::IMEM_DEPTH];
   procPkg::word_t pc;
   procPkg::word_t pcInc;
   procPkg::word_t fetched;
   logic           stopped;
   logic           advance;

   assign pcInc   = pc + 16'd1;
   assign fetched = imem[procPkg::iAddr_t'(pc)];
   // Once HALT has been decoded nothing more is fetched
   assign advance = run && !stopped && !halt && !stall;

   always_ff @(posedge clk) begin
      if (progWe) begin
         imem[progAddr] <= progData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc      <= '0;
         instr   <= procPkg::NOP_INSTR;
         stopped <= 1'b0;
      end else begin
         if (halt) begin
            stopped <= 1'b1;
         end
         if (redirect) begin
            pc    <= target;
            instr <= procPkg::NOP_INSTR;
         end else if (advance) begin
            pc    <= pcInc;
            instr <= fetched;
         end else if (!stall) begin
            instr <= procPkg::NOP_INSTR;
         end
      end
   end

   // Return address travels alongside its instruction
   always_ff @(posedge clk) begin
      if (advance) begin
         pcNext <= pcInc;
      end
   end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps
/*
 * Eight 16-bit registers, two read ports and one write port with
 * write-through to a same-cycle read
 */
module regFile (
   input  logic              clk,
   input  logic              rstN,
   input  procPkg::regAddr_t rdAddrA,
   input  procPkg::regAddr_t rdAddrB,
   output procPkg::word_t    rdDataA,
   output procPkg::word_t    rdDataB,
   input  logic              wrEn,
   input  procPkg::regAddr_t wrAddr,
   input  procPkg::word_t    wrData
);

   procPkg::word_t regs [procPkg::REG_COUNT];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < procPkg::REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Write-through covers the write-back stage for hazard purposes
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

/* hdl/decode.sv */
`timescale 1ns/1ps
/*
 * Decode stage: opcode decode, immediate extension, RAW hazard stall,
 * illegal-opcode error and the decode-to-execute register
 */
module decode (
   input  logic              clk,
   input  logic              rstN,
   input  procPkg::word_t    instr,
   input  procPkg::word_t    pcNext,
   input  logic              flush,
   input  logic              wbEn,
   input  procPkg::regAddr_t wbReg,
   input  procPkg::word_t    wbData,
   input  procPkg::regAddr_t exDest,
   input  logic              exRegWrt,
   input  procPkg::regAddr_t memDest,
   input  logic              memRegWrt,
   output logic              stall,
   output logic              halt,
   output logic              err,
   output procPkg::word_t    opA,
   output procPkg::word_t    opB,
   output procPkg::word_t    imm,
   output procPkg::aluOp_t   aluOp,
   output logic              useImm,
   output logic              regWrt,
   output procPkg::regAddr_t dest,
   output logic              memRead,
   output logic              memWrt,
   output procPkg::brKind_t  branchKind,
   output procPkg::word_t    pcOut,
   output logic              haltOut
);

   procPkg::opcode_t  opc;
   procPkg::regAddr_t rs;
   procPkg::regAddr_t rt;
   procPkg::word_t    rdDataA;
   procPkg::word_t    rdDataB;
   procPkg::word_t    immC;
   procPkg::aluOp_t   aluOpC;
   procPkg::regAddr_t destC;
   procPkg::brKind_t  brC;
   logic              useImmC;
   logic              regWrtC;
   logic              memReadC;
   logic              memWrtC;
   logic              haltC;
   logic              illegal;
   logic              useRs;
   logic              useRt;
   logic              bubble;

   assign opc = procPkg::opcode_t'(instr[procPkg::OPC_MSB:procPkg::OPC_LSB]);
   assign rs  = instr[procPkg::RS_MSB:procPkg::RS_LSB];
   assign rt  = instr[procPkg::RT_MSB:procPkg::RT_LSB];

   regFile u_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (rs),
      .rdAddrB (rt),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wbEn),
      .wrAddr  (wbReg),
      .wrData  (wbData)
   );

   always_comb begin
      aluOpC   = procPkg::ALU_PASS_B;
      useImmC  = 1'b0;
      regWrtC  = 1'b0;
      destC    = instr[procPkg::RD_MSB:procPkg::RD_LSB];
      memReadC = 1'b0;
      memWrtC  = 1'b0;
      brC      = procPkg::BR_NONE;
      haltC    = 1'b0;
      illegal  = 1'b0;
      useRs    = 1'b0;
      useRt    = 1'b0;
      immC     = {{(procPkg::WORD_W-procPkg::IMM5_MSB-1){instr[procPkg::IMM5_MSB]}},
                  instr[procPkg::IMM5_MSB:0]};
      case (opc)
         procPkg::OP_ADD, procPkg::OP_SUB, procPkg::OP_AND, procPkg::OP_XOR: begin
            regWrtC = 1'b1;
            useRs   = 1'b1;
            useRt   = 1'b1;
            case (opc)
               procPkg::OP_ADD: aluOpC = procPkg::ALU_ADD;
               procPkg::OP_SUB: aluOpC = procPkg::ALU_SUB;
               procPkg::OP_AND: aluOpC = procPkg::ALU_AND;
               default:         aluOpC = procPkg::ALU_XOR;
            endcase
         end
         procPkg::OP_ADDI, procPkg::OP_LD: begin
            aluOpC   = procPkg::ALU_ADD;
            useImmC  = 1'b1;
            regWrtC  = 1'b1;
            destC    = rt;
            useRs    = 1'b1;
            memReadC = (opc == procPkg::OP_LD);
         end
         procPkg::OP_ST: begin
            aluOpC  = procPkg::ALU_ADD;
            useImmC = 1'b1;
            memWrtC = 1'b1;
            useRs   = 1'b1;
            useRt   = 1'b1;
         end
         procPkg::OP_BEQZ, procPkg::OP_BNEZ: begin
            brC   = (opc == procPkg::OP_BEQZ) ? procPkg::BR_EQZ : procPkg::BR_NEZ;
            useRs = 1'b1;
            immC  = {{(procPkg::WORD_W-procPkg::BOFF_MSB-1){instr[procPkg::BOFF_MSB]}},
                     instr[procPkg::BOFF_MSB:0]};
         end
         procPkg::OP_J: begin
            brC  = procPkg::BR_JMP;
            immC = {{(procPkg::WORD_W-procPkg::JOFF_MSB-1){instr[procPkg::JOFF_MSB]}},
                    instr[procPkg::JOFF_MSB:0]};
         end
         procPkg::OP_HALT: haltC = 1'b1;
         procPkg::OP_NOP:  ;
         // Unknown codes fall through as NOP but raise err
         default: illegal = 1'b1;
      endcase
   end

   // Sources in flight in execute or memory; write-back is seen through the register file
   assign stall = (useRs && ((exRegWrt && exDest == rs) || (memRegWrt && memDest == rs))) ||
                  (useRt && ((exRegWrt && exDest == rt) || (memRegWrt && memDest == rt)));
   assign halt   = haltC && !flush;
   assign bubble = stall || flush;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         regWrt     <= 1'b0;
         memRead    <= 1'b0;
         memWrt     <= 1'b0;
         branchKind <= procPkg::BR_NONE;
         haltOut    <= 1'b0;
         err        <= 1'b0;
      end else begin
         regWrt     <= regWrtC && !bubble;
         memRead    <= memReadC && !bubble;
         memWrt     <= memWrtC && !bubble;
         branchKind <= bubble ? procPkg::BR_NONE : brC;
         haltOut    <= haltC && !bubble;
         if (illegal && !flush) begin
            err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      opA    <= rdDataA;
      opB    <= rdDataB;
      imm    <= immC;
      aluOp  <= aluOpC;
      useImm <= useImmC;
      dest   <= destC;
      pcOut  <= pcNext;
   end

endmodule

/* hdl/execute.sv */
`timescale 1ns/1ps
/*
 * Execute stage: ALU, branch and jump resolution with redirect to fetch,
 * and the execute-to-memory register
 */
module execute (
   input  logic              clk,
   input  logic              rstN,
   input  procPkg::word_t    opA,
   input  procPkg::word_t    opB,
   input  procPkg::word_t    imm,
   input  procPkg::aluOp_t   aluOp,
   input  logic              useImm,
   input  logic              regWrt,
   input  procPkg::regAddr_t dest,
   input  logic              memRead,
   input  logic              memWrt,
   input  procPkg::brKind_t  branchKind,
   input  procPkg::word_t    pcOut,
   input  logic              haltIn,
   output logic              redirect,
   output procPkg::word_t    target,
   output procPkg::word_t    aluOut,
   output procPkg::word_t    storeData,
   output logic              regWrtQ,
   output procPkg::regAddr_t destQ,
   output logic              memReadQ,
   output logic              memWrtQ,
   output logic              haltOut,
   output procPkg::regAddr_t exDest,
   output logic              exRegWrt
);

   procPkg::word_t aluB;
   procPkg::word_t aluRes;

   assign aluB = useImm ? imm : opB;

   always_comb begin
      case (aluOp)
         procPkg::ALU_ADD: aluRes = opA + aluB;
         procPkg::ALU_SUB: aluRes = opA - aluB;
         procPkg::ALU_AND: aluRes = opA & aluB;
         procPkg::ALU_XOR: aluRes = opA ^ aluB;
         default:          aluRes = aluB;
      endcase
   end

   // Condition tests rs against zero; target is relative to the next PC
   always_comb begin
      case (branchKind)
         procPkg::BR_EQZ: redirect = (opA == '0);
         procPkg::BR_NEZ: redirect = (opA != '0);
         procPkg::BR_JMP: redirect = 1'b1;
         default:         redirect = 1'b0;
      endcase
   end

   assign target = pcOut + imm;

   // Destination of the instruction now in execute, for the hazard check
   assign exDest   = dest;
   assign exRegWrt = regWrt;

   // The branch itself moves on; only younger slots are flushed upstream
   always_ff @(posedge clk) begin
      if (!rstN) begin
         regWrtQ  <= 1'b0;
         memReadQ <= 1'b0;
         memWrtQ  <= 1'b0;
         haltOut  <= 1'b0;
      end else begin
         regWrtQ  <= regWrt;
         memReadQ <= memRead;
         memWrtQ  <= memWrt;
         haltOut  <= haltIn;
      end
   end

   always_ff @(posedge clk) begin
      aluOut    <= aluRes;
      storeData <= opB;
      destQ     <= dest;
   end

endmodule

/* hdl/memory.sv */
`timescale 1ns/1ps
/*
 * Memory stage: 256-word data memory, load and store, write-back
 * select and the retire register
 */
module memory (
   input  logic              clk,
   input  logic              rstN,
   input  procPkg::word_t    aluOut,
   input  procPkg::word_t    storeData,
   input  logic              regWrt,
   input  procPkg::regAddr_t dest,
   input  logic              memRead,
   input  logic              memWrt,
   input  logic              haltIn,
   output procPkg::regAddr_t memDest,
   output logic              memRegWrt,
   output logic              wbEn,
   output procPkg::regAddr_t wbReg,
   output procPkg::word_t    wbData,
   output logic              halted
);

   procPkg::word_t dmem [procPkg::DMEM_DEPTH];
   procPkg::dAddr_t addr;

   // Word address is the low byte of the ALU result
   assign addr = procPkg::dAddr_t'(aluOut);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < procPkg::DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (memWrt) begin
         dmem[addr] <= storeData;
      end
   end

   assign memDest   = dest;
   assign memRegWrt = regWrt;

   // halted is sticky until reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         wbEn   <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbEn <= regWrt;
         if (haltIn) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      wbReg  <= dest;
      wbData <= memRead ? dmem[addr] : aluOut;
   end

endmodule

/* hdl/proc.sv */
`timescale 1ns/1ps
/*
 * Processor top: five-stage in-order pipeline with program load port,
 * run control and retire trace outputs
 */
module proc (
   input  logic              clk,
   input  logic              rstN,
   input  logic              progWe,
   input  procPkg::iAddr_t   progAddr,
   input  procPkg::word_t    progData,
   input  logic              run,
   output logic              wbEn,
   output procPkg::regAddr_t wbReg,
   output procPkg::word_t    wbData,
   output logic              halted,
   output logic              err
);

   // Fetch to decode, and control back to fetch
   procPkg::word_t    ifInstr;
   procPkg::word_t    ifPcNext;
   logic              stall;
   logic              halt;
   logic              redirect;
   procPkg::word_t    target;

   // Decode to execute
   procPkg::word_t    idOpA;
   procPkg::word_t    idOpB;
   procPkg::word_t    idImm;
   procPkg::aluOp_t   idAluOp;
   logic              idUseImm;
   logic              idRegWrt;
   procPkg::regAddr_t idDest;
   logic              idMemRead;
   logic              idMemWrt;
   procPkg::brKind_t  idBranchKind;
   procPkg::word_t    idPc;
   logic              idHalt;

   // Execute to memory
   procPkg::word_t    exAluOut;
   procPkg::word_t    exStoreData;
   logic              exRegWrt;
   procPkg::regAddr_t exDest;
   logic              exMemRead;
   logic              exMemWrt;
   logic              exHalt;

   // Hazard feedback
   procPkg::regAddr_t fbExDest;
   logic              fbExRegWrt;
   procPkg::regAddr_t fbMemDest;
   logic              fbMemRegWrt;

   fetch u_fetch (
      .clk      (clk),
      .rstN     (rstN),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .run      (run),
      .stall    (stall),
      .halt     (halt),
      .redirect (redirect),
      .target   (target),
      .instr    (ifInstr),
      .pcNext   (ifPcNext)
   );

   decode u_decode (
      .clk        (clk),
      .rstN       (rstN),
      .instr      (ifInstr),
      .pcNext     (ifPcNext),
      .flush      (redirect),
      .wbEn       (wbEn),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .exDest     (fbExDest),
      .exRegWrt   (fbExRegWrt),
      .memDest    (fbMemDest),
      .memRegWrt  (fbMemRegWrt),
      .stall      (stall),
      .halt       (halt),
      .err        (err),
      .opA        (idOpA),
      .opB        (idOpB),
      .imm        (idImm),
      .aluOp      (idAluOp),
      .useImm     (idUseImm),
      .regWrt     (idRegWrt),
      .dest       (idDest),
      .memRead    (idMemRead),
      .memWrt     (idMemWrt),
      .branchKind (idBranchKind),
      .pcOut      (idPc),
      .haltOut    (idHalt)
   );

   execute u_execute (
      .clk        (clk),
      .rstN       (rstN),
      .opA        (idOpA),
      .opB        (idOpB),
      .imm        (idImm),
      .aluOp      (idAluOp),
      .useImm     (idUseImm),
      .regWrt     (idRegWrt),
      .dest       (idDest),
      .memRead    (idMemRead),
      .memWrt     (idMemWrt),
      .branchKind (idBranchKind),
      .pcOut      (idPc),
      .haltIn     (idHalt),
      .redirect   (redirect),
      .target     (target),
      .aluOut     (exAluOut),
      .storeData  (exStoreData),
      .regWrtQ    (exRegWrt),
      .destQ      (exDest),
      .memReadQ   (exMemRead),
      .memWrtQ    (exMemWrt),
      .haltOut    (exHalt),
      .exDest     (fbExDest),
      .exRegWrt   (fbExRegWrt)
   );

   memory u_memory (
      .clk       (clk),
      .rstN      (rstN),
      .aluOut    (exAluOut),
      .storeData (exStoreData),
      .regWrt    (exRegWrt),
      .dest      (exDest),
      .memRead   (exMemRead),
      .memWrt    (exMemWrt),
      .haltIn    (exHalt),
      .memDest   (fbMemDest),
      .memRegWrt (fbMemRegWrt),
      .wbEn      (wbEn),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .halted    (halted)
   );

endmodule

/* dv/procRetire_chk.sv */
`timescale 1ns/1ps
/*
 * Retire rules checked by assertion at the processor top level
 */
module procRetire_chk (
   input logic clk,
   input logic rstN,
   input logic wbEn,
   input logic halted,
   input logic err
);

   // Synchronous reset clears every retire output by the next cycle
   clearAfterReset: assert property (@(posedge clk) !rstN |=> (!wbEn && !halted && !err))
      else $error("wbEn, halted or err not low in the cycle after reset");

   // halted is sticky until reset
   haltedSticky: assert property (@(posedge clk) (rstN && halted) |=> halted)
      else $error("halted fell while rstN was high");

   noRetireWhenHalted: assert property (@(posedge clk) disable iff (!rstN) !(wbEn && halted))
      else $error("wbEn high while halted");

endmodule

bind proc procRetire_chk u_retireChk (
   .clk    (clk),
   .rstN   (rstN),
   .wbEn   (wbEn),
   .halted (halted),
   .err    (err)
);

/* dv/procScoreboard.sv */
`timescale 1ns/1ps
/*
 * Instruction-set model of the processor that checks the retire trace,
 * halt and err at the top-level ports and counts errors
 */
module procScoreboard (
   input  logic              clk,
   input  logic              rstN,
   input  logic              progWe,
   input  procPkg::iAddr_t   progAddr,
   input  procPkg::word_t    progData,
   input  logic              run,
   input  logic              wbEn,
   input  procPkg::regAddr_t wbReg,
   input  procPkg::word_t    wbData,
   input  logic              halted,
   input  logic              err,
   output int                errCount,
   output int                retireCount,
   output int                progCount
);

   procPkg::word_t    imemCopy [procPkg::IMEM_DEPTH];
   procPkg::regAddr_t expReg [$];
   procPkg::word_t    expData [$];
   logic              expErr;
   logic              runSeen;
   logic              haltSeen;
   logic              inReset;

   initial begin
      errCount    = 0;
      retireCount = 0;
      progCount   = 0;
      expErr      = 1'b0;
      runSeen     = 1'b0;
      haltSeen    = 1'b0;
      inReset     = 1'b0;
   end

   task automatic reportMismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
      errCount++;
      $display("[ERROR] t=%0t %s expected %h, got %h", $time, name, expected, actual);
   endtask

   task automatic reportFailure(input string what);
      errCount++;
      $display("Failure at t=%0t: %s", $time, what);
   endtask

   // Runs the loaded program up to HALT and queues every register write
   task automatic buildExpected();
      procPkg::word_t    regs [procPkg::REG_COUNT];
      procPkg::word_t    dmem [procPkg::DMEM_DEPTH];
      procPkg::word_t    ins;
      procPkg::word_t    pc;
      procPkg::word_t    imm5;
      procPkg::word_t    wrData;
      procPkg::regAddr_t rs;
      procPkg::regAddr_t rt;
      procPkg::regAddr_t wrAddr;
      procPkg::opcode_t  opc;
      logic              wrEn;
      logic              done;
      int                steps;
      foreach (regs[i]) regs[i] = '0;
      foreach (dmem[i]) dmem[i] = '0;
      expReg.delete();
      expData.delete();
      expErr = 1'b0;
      pc     = '0;
      done   = 1'b0;
      steps  = 0;
      while (!done && steps < 1000) begin
         ins    = imemCopy[pc[7:0]];
         opc    = procPkg::opcode_t'(ins[15:11]);
         rs     = ins[10:8];
         rt     = ins[7:5];
         imm5   = {{11{ins[4]}}, ins[4:0]};
         wrEn   = 1'b1;
         wrAddr = ins[4:2];
         wrData = '0;
         pc     = pc + 16'd1;
         steps++;
         case (opc)
            procPkg::OP_ADD:  wrData = regs[rs] + regs[rt];
            procPkg::OP_SUB:  wrData = regs[rs] - regs[rt];
            procPkg::OP_AND:  wrData = regs[rs] & regs[rt];
            procPkg::OP_XOR:  wrData = regs[rs] ^ regs[rt];
            procPkg::OP_ADDI: begin
               wrAddr = rt;
               wrData = regs[rs] + imm5;
            end
            procPkg::OP_LD: begin
               wrAddr = rt;
               wrData = dmem[procPkg::dAddr_t'(regs[rs] + imm5)];
            end
            procPkg::OP_ST: begin
               wrEn = 1'b0;
               dmem[procPkg::dAddr_t'(regs[rs] + imm5)] = regs[rt];
            end
            procPkg::OP_BEQZ: begin
               wrEn = 1'b0;
               if (regs[rs] == '0) pc = pc + {{8{ins[7]}}, ins[7:0]};
            end
            procPkg::OP_BNEZ: begin
               wrEn = 1'b0;
               if (regs[rs] != '0) pc = pc + {{8{ins[7]}}, ins[7:0]};
            end
            procPkg::OP_J: begin
               wrEn = 1'b0;
               pc   = pc + {{5{ins[10]}}, ins[10:0]};
            end
            procPkg::OP_HALT: begin
               wrEn = 1'b0;
               done = 1'b1;
            end
            procPkg::OP_NOP: wrEn = 1'b0;
            // Undefined opcode behaves as NOP and raises err
            default: begin
               wrEn   = 1'b0;
               expErr = 1'b1;
            end
         endcase
         if (wrEn) begin
            regs[wrAddr] = wrData;
            expReg.push_back(wrAddr);
            expData.push_back(wrData);
         end
      end
      if (!done) reportFailure("model found no HALT within 1000 instructions");
   endtask

   task automatic checkRetire();
      if (halted) reportFailure("wbEn high while halted");
      if (expReg.size() == 0) begin
         reportFailure("retirement with no register write left in the model");
      end else begin
         if (wbReg !== expReg[0]) reportMismatch("wbReg", 16'(expReg[0]), 16'(wbReg));
         if (wbData !== expData[0]) reportMismatch("wbData", expData[0], wbData);
         void'(expReg.pop_front());
         void'(expData.pop_front());
         retireCount++;
      end
   endtask

   task automatic checkHalt();
      progCount++;
      if (expReg.size() != 0) begin
         reportFailure($sformatf("halted with %0d register writes not retired", expReg.size()));
      end
      if (err !== expErr) reportMismatch("err", 16'(expErr), 16'(err));
   endtask

   // Outputs are registered, so the values read at the rising edge are stable
   always @(posedge clk) begin
      if (progWe) begin
         imemCopy[progAddr] = progData;
      end
      if (!rstN) begin
         inReset  = 1'b1;
         haltSeen = 1'b0;
      end else begin
         if (inReset && (wbEn || halted || err)) begin
            reportFailure("wbEn, halted or err not low in the cycle after reset");
         end
         inReset = 1'b0;
         if (run && !runSeen) buildExpected();
         if (wbEn) checkRetire();
         if (haltSeen && !halted) reportFailure("halted fell without a reset");
         if (halted && !haltSeen) checkHalt();
         haltSeen = halted;
      end
      runSeen = run;
   end

endmodule

/* dv/procTb.sv */
`timescale 1ns/1ps
/*
 * Processor testbench: seeded random programs, program load, run
 * control, watchdog and the closing summary
 */
module procTb;

   localparam int NUM_PROGS   = 20;
   localparam int PROG_LEN    = 64;
   localparam int CLK_PERIOD  = 4;
   localparam int LOAD_CYCLES = 320;
   localparam int RUN_CYCLES  = PROG_LEN * 4;
   // Twice the nominal length of all programs
   localparam int TIMEOUT_NS  = 2 * NUM_PROGS * (LOAD_CYCLES + RUN_CYCLES) * CLK_PERIOD;

   logic              clk;
   logic              rstN;
   logic              progWe;
   procPkg::iAddr_t   progAddr;
   procPkg::word_t    progData;
   logic              run;
   logic              wbEn;
   procPkg::regAddr_t wbReg;
   procPkg::word_t    wbData;
   logic              halted;
   logic              err;
   int                errCount;
   int                retireCount;
   int                progCount;

   proc i_dut (
      .clk      (clk),
      .rstN     (rstN),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .run      (run),
      .wbEn     (wbEn),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .halted   (halted),
      .err      (err)
   );

   procScoreboard u_scoreboard (
      .clk         (clk),
      .rstN        (rstN),
      .progWe      (progWe),
      .progAddr    (progAddr),
      .progData    (progData),
      .run         (run),
      .wbEn        (wbEn),
      .wbReg       (wbReg),
      .wbData      (wbData),
      .halted      (halted),
      .err         (err),
      .errCount    (errCount),
      .retireCount (retireCount),
      .progCount   (progCount)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Forward offsets only, and never past the HALT at PROG_LEN
   function automatic procPkg::word_t randomInstr(input int idx, input procPkg::word_t prev);
      int unsigned pick;
      int unsigned room;
      int unsigned off;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic [2:0]  rd;
      logic [4:0]  imm;
      pick = $urandom % 16;
      rs   = 3'($urandom);
      rt   = 3'($urandom);
      rd   = 3'($urandom);
      imm  = 5'($urandom);
      room = PROG_LEN - 1 - idx;
      off  = (room == 0) ? 0 : 1 + $urandom % ((room < 6) ? room : 6);
      // A load right after a store often reads the same word back
      if (prev[15:11] == procPkg::OP_ST && pick < 8) begin
         return {procPkg::OP_LD, prev[10:8], rt, prev[4:0]};
      end
      case (pick)
         0:                return {procPkg::OP_ADD, rs, rt, rd, 2'b00};
         1:                return {procPkg::OP_SUB, rs, rt, rd, 2'b00};
         2:                return {procPkg::OP_AND, rs, rt, rd, 2'b00};
         3:                return {procPkg::OP_XOR, rs, rt, rd, 2'b00};
         4, 5, 6, 14, 15:  return {procPkg::OP_ADDI, rs, rt, imm};
         7:                return {procPkg::OP_LD, rs, rt, imm};
         8, 9:             return {procPkg::OP_ST, rs, rt, imm};
         10:               return {procPkg::OP_BEQZ, rs, 8'(off)};
         11:               return {procPkg::OP_BNEZ, rs, 8'(off)};
         12:               return {procPkg::OP_J, 11'(off)};
         default:          return 16'h0000;
      endcase
   endfunction

   task automatic applyReset();
      @(negedge clk);
      rstN = 1'b0;
      repeat (5) @(negedge clk);
      rstN = 1'b1;
   endtask

   // Every fourth program carries one undefined opcode
   task automatic loadProgram(input int progNum);
      procPkg::word_t instr;
      procPkg::word_t prev;
      int             illegalPos;
      prev       = 16'h0000;
      illegalPos = (progNum % 4 == 3) ? int'($urandom % PROG_LEN) : -1;
      for (int i = 0; i <= PROG_LEN; i++) begin
         if (i == PROG_LEN) begin
            instr = {procPkg::OP_HALT, 11'd0};
         end else if (i == illegalPos) begin
            instr = {5'(12 + $urandom % 20), 11'($urandom)};
         end else begin
            instr = randomInstr(i, prev);
         end
         prev = instr;
         @(negedge clk);
         progWe   = 1'b1;
         progAddr = procPkg::iAddr_t'(i);
         progData = instr;
      end
      @(negedge clk);
      progWe = 1'b0;
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns: a program never reached halted", TIMEOUT_NS);
      $display("sim failed");
      $finish;
   end

   initial begin
      void'($urandom(32'hd5d24d21));
      rstN     = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      run      = 1'b0;
      for (int p = 0; p < NUM_PROGS; p++) begin
         applyReset();
         loadProgram(p);
         @(negedge clk);
         run = 1'b1;
         while (!halted) @(negedge clk);
         run = 1'b0;
         // A few idle cycles show that nothing retires after halt
         repeat (3) @(negedge clk);
      end
      repeat (2) @(negedge clk);
      $display("Done: %0d programs, %0d retirements checked, %0d errors",
               progCount, retireCount, errCount);
      if (errCount == 0 && progCount == NUM_PROGS) begin
         $display("sim passed");
      end else begin
         if (progCount != NUM_PROGS) begin
            $display("Only %0d of %0d programs were checked at halt", progCount, NUM_PROGS);
         end
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* flist.f */
hdl/procPkg.sv
hdl/fetch.sv
hdl/regFile.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
dv/procRetire_chk.sv
dv/procScoreboard.sv
dv/procTb.sv

/* runSim.sh */
#!/bin/sh
# Build the processor testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
   verilator --binary --timing --assert --top-module procTb -f flist.f -o procSim &&
   ./obj_dir/procSim +verilator+error+limit+100 | tee /dev/stderr |
      grep -x "sim passed" > /dev/null &&
   echo "Simulation OK" ||
   { echo "Simulation FAILED"; exit 1; }
